// ==== sim.f ====
+incdir+source
+incdir+tests
source/wbPkg.sv
source/regWriteStage.sv
source/regFile.sv
source/trapCsr.sv
source/writebackUnit.sv
tests/writebackUnitTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the writeback unit testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
simBin=writebackUnitSim
logFile=sim.log

verilator --binary --timing --assert -f sim.f \
    --top-module writebackUnitTb -Mdir "$buildDir" -o "$simBin"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$buildDir/$simBin" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q "TESTBENCH FAILED" "$logFile"; then
    exit 1
fi
exit 0

// ==== tests/wbModel.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// writeback reference model
// architectural state of both register files and
// the trap CSRs, with the commit, redirect and
// CSR read rules of the writeback unit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef WB_MODEL_SVH
`define WB_MODEL_SVH

wordT modelInt [`WB_NREGS];
wordT modelFp [`WB_NREGS];
wordT modelMtvec;
wordT modelMepc;
wordT modelMcause;
wordT modelMtval;
wordT modelMinstret;
privT modelPriv;
privT modelMpp;

// everything zero, machine mode
function automatic void modelReset();
    for (int i = 0; i < `WB_NREGS; i++) begin
        modelInt[i] = '0;
        modelFp[i] = '0;
    end
    modelMtvec = '0;
    modelMepc = '0;
    modelMcause = '0;
    modelMtval = '0;
    modelMinstret = '0;
    modelPriv = privMachine;
    modelMpp = privUser;
endfunction

// redirect seen in the cycle of the result, uses state before it
function automatic redirectT modelRedirect(input execResultT r);
    redirectT redir;
    redir.valid = 1'b0;
    redir.target = '0;
    if (r.valid && r.trapValid) begin
        redir.valid = 1'b1;
        redir.target = modelMtvec;
    end else if (r.valid && r.trapReturn) begin
        redir.valid = 1'b1;
        redir.target = modelMepc;
    end
    return redir;
endfunction

// state update at the end of the cycle
function automatic void modelCommit(input execResultT r);
    if (r.valid && r.trapValid) begin
        // trap wins, nothing of the instruction itself is written
        modelMepc = r.pc;
        modelMcause = wordT'(r.trapCause);
        modelMtval = r.trapValue;
        modelMpp = modelPriv;
        modelPriv = privMachine;
    end else if (r.valid) begin
        // x0 stays zero, f0 is ordinary
        if (r.intWriteEnable && r.rd != '0) begin
            modelInt[r.rd] = r.intValue;
        end
        if (r.fpWriteEnable) begin
            modelFp[r.rd] = r.fpValue;
        end
        if (r.csrWriteEnable) begin
            case (r.csrAddr)
                `WB_CSR_MTVEC: modelMtvec = r.csrValue & ~wordT'(3);
                `WB_CSR_MEPC: modelMepc = r.csrValue;
                `WB_CSR_MCAUSE: modelMcause = r.csrValue;
                `WB_CSR_MTVAL: modelMtval = r.csrValue;
                default: ;
            endcase
        end
        if (r.trapReturn) begin
            modelPriv = modelMpp;
            modelMpp = privUser;
        end
        modelMinstret = modelMinstret + 1;
    end
endfunction

// mstatus shows MPP only, unknown numbers read zero
function automatic wordT modelCsrRead(input csrAddrT a);
    case (a)
        `WB_CSR_MSTATUS: return wordT'(modelMpp) << 11;
        `WB_CSR_MTVEC: return modelMtvec;
        `WB_CSR_MEPC: return modelMepc;
        `WB_CSR_MCAUSE: return modelMcause;
        `WB_CSR_MTVAL: return modelMtval;
        `WB_CSR_MINSTRET: return modelMinstret;
        default: return '0;
    endcase
endfunction

`endif

// ==== tests/writebackUnitTb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// writebackUnitTb
// drives execute results into the writeback unit
// and checks read ports and redirects against the
// reference model with one expectation per cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "wbParams.svh"

module writebackUnitTb
    import wbPkg::*;
();

    logic clk;
    logic rstN;
    execResultT execResult;
    regAddrT intReadAddr;
    wordT intReadValue;
    regAddrT fpReadAddr;
    wordT fpReadValue;
    csrAddrT csrReadAddr;
    wordT csrReadValue;
    redirectT redirect;

    // what the ports must show in one cycle
    typedef struct packed {
        regAddrT intAddr;
        wordT intValue;
        regAddrT fpAddr;
        wordT fpValue;
        csrAddrT csrAddr;
        wordT csrValue;
        redirectT redirect;
    } expectT;

    expectT expectQ [$];
    logic [31:0] rngState;
    int errorCount;
    int testsPassed;
    int testsFailed;
    bit timedOut;

    // 12'h7C0 is no CSR of this design and reads zero
    csrAddrT csrList [8] = '{`WB_CSR_MSTATUS, `WB_CSR_MTVEC, `WB_CSR_MEPC,
        `WB_CSR_MCAUSE, `WB_CSR_MTVAL, `WB_CSR_MINSTRET, 12'h7C0, `WB_CSR_MEPC};

    `include "wbModel.svh"

    writebackUnit writebackUnit_i (
        .clk(clk),
        .rstN(rstN),
        .execResult(execResult),
        .intReadAddr(intReadAddr),
        .intReadValue(intReadValue),
        .fpReadAddr(fpReadAddr),
        .fpReadValue(fpReadValue),
        .csrReadAddr(csrReadAddr),
        .csrReadValue(csrReadValue),
        .redirect(redirect)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    initial begin
        rstN = 1'b0;
        repeat (16) @(posedge clk);
        rstN <= 1'b1;
    end

    // xorshift32 step that advances the shared state
    function automatic logic [31:0] nextRandom();
        logic [31:0] x;
        x = rngState;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rngState = x;
        return x;
    endfunction

    // plain committed result with random fields
    function automatic execResultT randomResult();
        execResultT r;
        logic [31:0] bits;
        bits = nextRandom();
        r = '0;
        r.valid = 1'b1;
        r.pc = nextRandom() & 32'hFFFF_FFFC;
        r.rd = bits[4:0];
        r.intWriteEnable = bits[5];
        r.fpWriteEnable = bits[6];
        r.intValue = nextRandom();
        r.fpValue = nextRandom();
        r.csrAddr = csrList[bits[10:8]];
        r.csrValue = nextRandom();
        r.trapCause = bits[14:11];
        r.trapValue = nextRandom();
        return r;
    endfunction

    // drives one result and the read addresses and queues the model's expectation
    task automatic step(input execResultT r, input regAddrT ia, input regAddrT fa,
            input csrAddrT ca);
        expectT e;
        @(posedge clk);
        execResult <= r;
        intReadAddr <= ia;
        fpReadAddr <= fa;
        csrReadAddr <= ca;
        e.intAddr = ia;
        e.intValue = modelInt[ia];
        e.fpAddr = fa;
        e.fpValue = modelFp[fa];
        e.csrAddr = ca;
        e.csrValue = modelCsrRead(ca);
        e.redirect = modelRedirect(r);
        modelCommit(r);
        expectQ.push_back(e);
    endtask

    // compare at the falling edge when the outputs have settled
    initial begin
        expectT want;
        forever begin
            @(negedge clk);
            if (expectQ.size() > 0) begin
                want = expectQ.pop_front();
                assert (intReadValue == want.intValue) else begin
                    $display("FAIL %0t: x%0d reads %h, expected %h", $time,
                        want.intAddr, intReadValue, want.intValue);
                    errorCount++;
                end
                assert (fpReadValue == want.fpValue) else begin
                    $display("FAIL %0t: f%0d reads %h, expected %h", $time,
                        want.fpAddr, fpReadValue, want.fpValue);
                    errorCount++;
                end
                assert (csrReadValue == want.csrValue) else begin
                    $display("FAIL %0t: csr %h reads %h, expected %h", $time,
                        want.csrAddr, csrReadValue, want.csrValue);
                    errorCount++;
                end
                // target only matters while valid
                assert (redirect.valid == want.redirect.valid && (!want.redirect.valid
                        || redirect.target == want.redirect.target)) else begin
                    $display("FAIL %0t: redirect %b/%h, expected %b/%h", $time,
                        redirect.valid, redirect.target, want.redirect.valid,
                        want.redirect.target);
                    errorCount++;
                end
            end
        end
    end

    task automatic waitResetRelease();
        int waited;
        waited = 0;
        while (rstN !== 1'b1 && waited < 40) begin
            @(posedge clk);
            waited++;
        end
        if (rstN !== 1'b1) begin
            $display("timeout: reset was never released");
            timedOut = 1'b1;
        end
    endtask

    // wait until every expectation is compared and report the test
    task automatic finishTest(input string name, input int errorsBefore);
        int waited;
        waited = 0;
        while (expectQ.size() != 0 && waited < 8) begin
            @(posedge clk);
            waited++;
        end
        if (expectQ.size() != 0) begin
            $display("timeout: compare process left expected values unchecked");
            timedOut = 1'b1;
        end
        if (timedOut || errorCount != errorsBefore) begin
            $display("test %s: failed, %0d errors", name, errorCount - errorsBefore);
            testsFailed++;
        end else begin
            $display("test %s: ok", name);
            testsPassed++;
        end
    endtask

    task automatic testResetState();
        int errorsBefore;
        errorsBefore = errorCount;
        for (int i = 0; i < `WB_NREGS; i++) begin
            step('0, regAddrT'(i), regAddrT'(i), csrList[i[2:0]]);
        end
        finishTest("reset state", errorsBefore);
    endtask

    task automatic testCommittedWrites();
        int errorsBefore;
        execResultT r;
        regAddrT lastRd;
        errorsBefore = errorCount;
        lastRd = '0;
        for (int i = 0; i < 64; i++) begin
            r = randomResult();
            // every eighth slot is empty but still carries enables
            r.valid = (i[2:0] != 3'd7);
            if (!r.valid) begin
                r.intWriteEnable = 1'b1;
                r.fpWriteEnable = 1'b1;
            end
            if (i < 2) begin
                r.rd = '0;
                r.intWriteEnable = 1'b1;
                r.fpWriteEnable = 1'b1;
            end
            step(r, lastRd, lastRd, `WB_CSR_MINSTRET);
            lastRd = r.rd;
        end
        step('0, lastRd, lastRd, `WB_CSR_MINSTRET);
        finishTest("committed writes", errorsBefore);
    endtask

    task automatic testTraps();
        int errorsBefore;
        execResultT r;
        errorsBefore = errorCount;
        // known trap vector first
        r = randomResult();
        r.intWriteEnable = 1'b0;
        r.fpWriteEnable = 1'b0;
        r.csrWriteEnable = 1'b1;
        r.csrAddr = `WB_CSR_MTVEC;
        step(r, 5'd7, 5'd7, `WB_CSR_MTVEC);
        // trap that also asks for every write and an mret
        r = randomResult();
        r.rd = 5'd7;
        r.intWriteEnable = 1'b1;
        r.fpWriteEnable = 1'b1;
        r.csrWriteEnable = 1'b1;
        r.csrAddr = `WB_CSR_MTVEC;
        r.trapValid = 1'b1;
        r.trapReturn = 1'b1;
        // illegal instruction, differs from the reset value of mcause
        r.trapCause = 4'd2;
        step(r, 5'd7, 5'd7, `WB_CSR_MTVEC);
        step('0, 5'd7, 5'd7, `WB_CSR_MEPC);
        step('0, 5'd7, 5'd7, `WB_CSR_MCAUSE);
        step('0, 5'd7, 5'd7, `WB_CSR_MTVAL);
        step('0, 5'd7, 5'd7, `WB_CSR_MSTATUS);
        step('0, 5'd7, 5'd7, `WB_CSR_MTVEC);
        finishTest("traps", errorsBefore);
    endtask

    task automatic testCsrAndReturn();
        int errorsBefore;
        execResultT r;
        errorsBefore = errorCount;
        r = randomResult();
        r.intWriteEnable = 1'b0;
        r.fpWriteEnable = 1'b0;
        r.csrWriteEnable = 1'b1;
        r.csrAddr = `WB_CSR_MTVEC;
        r.csrValue = nextRandom() | 32'h3;
        step(r, '0, '0, `WB_CSR_MSTATUS);
        r.csrAddr = `WB_CSR_MEPC;
        r.csrValue = nextRandom();
        step(r, '0, '0, `WB_CSR_MTVEC);
        // mret goes back to the mepc just written
        r.csrWriteEnable = 1'b0;
        r.trapReturn = 1'b1;
        step(r, '0, '0, `WB_CSR_MEPC);
        step('0, '0, '0, `WB_CSR_MSTATUS);
        step('0, '0, '0, `WB_CSR_MINSTRET);
        finishTest("csr writes and mret", errorsBefore);
    endtask

    task automatic testRandomMix();
        int errorsBefore;
        execResultT r;
        logic [31:0] kind;
        errorsBefore = errorCount;
        for (int i = 0; i < 400; i++) begin
            r = randomResult();
            kind = nextRandom();
            case (kind[2:0])
                3'd0: begin
                    r.valid = 1'b0;
                    r.trapValid = kind[3];
                    r.trapReturn = kind[4];
                end
                3'd1: begin
                    r.trapValid = 1'b1;
                    r.trapReturn = kind[3];
                    r.csrWriteEnable = kind[4];
                end
                3'd2: r.trapReturn = 1'b1;
                3'd3: r.csrWriteEnable = 1'b1;
                default: ;
            endcase
            step(r, kind[12:8], kind[17:13], csrList[kind[20:18]]);
        end
        step('0, '0, '0, `WB_CSR_MINSTRET);
        finishTest("random mix", errorsBefore);
    endtask

    initial begin
        execResult = '0;
        intReadAddr = '0;
        fpReadAddr = '0;
        csrReadAddr = '0;
        rngState = 32'hedf1;
        errorCount = 0;
        testsPassed = 0;
        testsFailed = 0;
        timedOut = 1'b0;
        modelReset();
        waitResetRelease();
        if (!timedOut) begin
            testResetState();
            testCommittedWrites();
            testTraps();
            testCsrAndReturn();
            testRandomMix();
        end
        $display("tests passed %0d, tests failed %0d, check errors %0d",
            testsPassed, testsFailed, errorCount);
        if (timedOut || testsFailed != 0) begin
            $display("TESTBENCH FAILED");
        end else begin
            $display("TESTBENCH PASSED");
        end
        $finish;
    end

endmodule

// ==== source/writebackUnit.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// writebackUnit
// commit end of the pipeline: write-back stage,
// integer and float register files, trap CSRs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module writebackUnit
    import wbPkg::*;
(
    input logic clk,
    input logic rstN,
    input execResultT execResult,
    input regAddrT intReadAddr,
    output wordT intReadValue,
    input regAddrT fpReadAddr,
    output wordT fpReadValue,
    input csrAddrT csrReadAddr,
    output wordT csrReadValue,
    output redirectT redirect
);

    regWriteT intWrite;
    regWriteT fpWrite;
    trapEventT trapEvent;

    // commit or trap decision
    regWriteStage regWriteStage_i (
        .clk(clk),
        .rstN(rstN),
        .execResult(execResult),
        .intWrite(intWrite),
        .fpWrite(fpWrite),
        .trapEvent(trapEvent)
    );

    // x registers, x0 reads zero
    regFile #(.hasZeroReg(1'b1)) intRegFile_i (
        .clk(clk),
        .rstN(rstN),
        .write(intWrite),
        .readAddr(intReadAddr),
        .readValue(intReadValue)
    );

    // f registers, f0 is an ordinary register
    regFile #(.hasZeroReg(1'b0)) fpRegFile_i (
        .clk(clk),
        .rstN(rstN),
        .write(fpWrite),
        .readAddr(fpReadAddr),
        .readValue(fpReadValue)
    );

    trapCsr trapCsr_i (
        .clk(clk),
        .rstN(rstN),
        .trapEvent(trapEvent),
        .csrReadAddr(csrReadAddr),
        .csrReadValue(csrReadValue),
        .redirect(redirect)
    );

endmodule

// ==== source/trapCsr.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// trapCsr
// machine trap CSRs, privilege mode and minstret
// updated at commit, plus the fetch redirect for
// traps and mret
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "wbParams.svh"

module trapCsr
    import wbPkg::*;
(
    input logic clk,
    input logic rstN,
    input trapEventT trapEvent,
    input csrAddrT csrReadAddr,
    output wordT csrReadValue,
    output redirectT redirect
);

    wordT mtvec;
    wordT mepc;
    wordT mcause;
    wordT mtval;
    wordT minstret;

    // current mode and the mode saved by the last trap
    privT priv;
    privT mpp;

    // trap vector, mepc and friends
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            mtvec <= '0;
            mepc <= '0;
            mcause <= '0;
            mtval <= '0;
        end else if (trapEvent.trapValid) begin
            mepc <= trapEvent.trapPc;
            // cause is zero extended into the full word
            mcause <= wordT'(trapEvent.trapCause);
            mtval <= trapEvent.trapValue;
        end else if (trapEvent.csrWriteEnable) begin
            case (trapEvent.csrAddr)
                // direct mode only, base stays word aligned
                `WB_CSR_MTVEC: mtvec <= {trapEvent.csrValue[`WB_XLEN-1:2], 2'b00};
                `WB_CSR_MEPC: mepc <= trapEvent.csrValue;
                `WB_CSR_MCAUSE: mcause <= trapEvent.csrValue;
                `WB_CSR_MTVAL: mtval <= trapEvent.csrValue;
                // writes to mstatus, minstret or unknown numbers are ignored
                default: ;
            endcase
        end
    end

    // privilege stack, one level deep
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            priv <= privMachine;
            mpp <= privUser;
        end else if (trapEvent.trapValid) begin
            mpp <= priv;
            priv <= privMachine;
        end else if (trapEvent.returnValid) begin
            priv <= mpp;
            mpp <= privUser;
        end
    end

    // mret retires too and is counted
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            minstret <= '0;
        end else if (trapEvent.commit) begin
            minstret <= minstret + wordT'(1);
        end
    end

    // combinational read, unknown numbers return zero
    always_comb begin
        csrReadValue = '0;
        case (csrReadAddr)
            // MPP lives at bits 12:11
            `WB_CSR_MSTATUS: csrReadValue[12:11] = mpp;
            `WB_CSR_MTVEC: csrReadValue = mtvec;
            `WB_CSR_MEPC: csrReadValue = mepc;
            `WB_CSR_MCAUSE: csrReadValue = mcause;
            `WB_CSR_MTVAL: csrReadValue = mtval;
            `WB_CSR_MINSTRET: csrReadValue = minstret;
            default: csrReadValue = '0;
        endcase
    end

    // redirect uses the CSR values from before this edge
    always_comb begin
        redirect.valid = trapEvent.trapValid || trapEvent.returnValid;
        redirect.target = trapEvent.trapValid ? mtvec : mepc;
    end

    // the stage must resolve trap against mret before it gets here
    trapNotWithReturn: assert property (
        @(posedge clk) disable iff (!rstN)
        !(trapEvent.trapValid && trapEvent.returnValid)
    ) else $error("trap and mret reported in the same cycle");

endmodule

// ==== source/regFile.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// regFile
// 32 word register file, one write port and one
// combinational read port, x0 optionally zero
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "wbParams.svh"

module regFile
    import wbPkg::*;
#(
    // integer file ties register 0 to zero, float file does not
    parameter bit hasZeroReg = 1'b1
) (
    input logic clk,
    input logic rstN,
    input regWriteT write,
    input regAddrT readAddr,
    output wordT readValue
);

    wordT regs [`WB_NREGS];

    // write to register 0 goes nowhere when it is hardwired
    logic writeDropped;

    always_comb begin
        writeDropped = hasZeroReg && (write.addr == '0);
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `WB_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write.enable && !writeDropped) begin
            regs[write.addr] <= write.value;
        end
    end

    // read sees the old value during a same-cycle write
    always_comb begin
        if (hasZeroReg && (readAddr == '0)) begin
            readValue = '0;
        end else begin
            readValue = regs[readAddr];
        end
    end

endmodule

// ==== source/regWriteStage.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// regWriteStage
// decides commit or trap for the execute result
// and drives the register file and CSR writes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module regWriteStage
    import wbPkg::*;
(
    input logic clk,
    input logic rstN,
    input execResultT execResult,
    output regWriteT intWrite,
    output regWriteT fpWrite,
    output trapEventT trapEvent
);

    // instruction retires normally
    logic commit;
    // instruction raises an exception instead
    logic trapTaken;

    always_comb begin
        commit = execResult.valid && !execResult.trapValid;
        trapTaken = execResult.valid && execResult.trapValid;
    end

    // register file writes, only on commit
    always_comb begin
        intWrite.enable = commit && execResult.intWriteEnable;
        intWrite.addr = execResult.rd;
        intWrite.value = execResult.intValue;

        // float results share rd with the integer side
        fpWrite.enable = commit && execResult.fpWriteEnable;
        fpWrite.addr = execResult.rd;
        fpWrite.value = execResult.fpValue;
    end

    // trap side of the commit
    always_comb begin
        trapEvent.trapValid = trapTaken;
        trapEvent.trapCause = execResult.trapCause;
        trapEvent.trapValue = execResult.trapValue;
        trapEvent.trapPc = execResult.pc;

        // a trap wins over mret, commit already excludes it
        trapEvent.returnValid = commit && execResult.trapReturn;

        // csr write also dropped on a trap
        trapEvent.csrWriteEnable = commit && execResult.csrWriteEnable;
        trapEvent.csrAddr = execResult.csrAddr;
        trapEvent.csrValue = execResult.csrValue;

        // feeds minstret
        trapEvent.commit = commit;
    end

    // a trapping instruction leaves no architectural write behind
    noWriteOnTrap: assert property (
        @(posedge clk) disable iff (!rstN)
        (execResult.valid && execResult.trapValid)
            |-> !(intWrite.enable || fpWrite.enable || trapEvent.csrWriteEnable)
    ) else $error("register or CSR write enabled on a trap");

endmodule

// ==== source/wbPkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// wbPkg
// shared types of the writeback unit: data words,
// register and CSR numbers, privilege modes and
// the packed buses between the stages
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "wbParams.svh"

package wbPkg;

    typedef logic [`WB_XLEN-1:0] wordT;
    typedef logic [$clog2(`WB_NREGS)-1:0] regAddrT;
    typedef logic [11:0] csrAddrT;
    // exception code as written to mcause
    typedef logic [3:0] causeT;

    // only user and machine modes exist here
    typedef enum logic [1:0] {
        privUser = 2'd0,
        privMachine = 2'd3
    } privT;

    // one result per cycle from execute
    typedef struct packed {
        logic valid;
        wordT pc;
        regAddrT rd;
        logic intWriteEnable;
        logic fpWriteEnable;
        wordT intValue;
        wordT fpValue;
        logic csrWriteEnable;
        csrAddrT csrAddr;
        wordT csrValue;
        logic trapValid;
        causeT trapCause;
        wordT trapValue;
        // set for mret
        logic trapReturn;
    } execResultT;

    // write port of a register file
    typedef struct packed {
        logic enable;
        regAddrT addr;
        wordT value;
    } regWriteT;

    // everything the CSR block needs from commit
    typedef struct packed {
        logic trapValid;
        causeT trapCause;
        wordT trapValue;
        wordT trapPc;
        logic returnValid;
        logic csrWriteEnable;
        csrAddrT csrAddr;
        wordT csrValue;
        logic commit;
    } trapEventT;

    // new fetch address after a trap or mret
    typedef struct packed {
        logic valid;
        wordT target;
    } redirectT;

endpackage

// ==== source/wbParams.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// writeback parameters
// data width, register count and the numbers of
// the machine CSRs handled at commit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef WB_PARAMS_SVH
`define WB_PARAMS_SVH

// data path width of both register files
`define WB_XLEN 32

// entries per register file
`define WB_NREGS 32

// machine CSR numbers
// mstatus only exposes the MPP field
`define WB_CSR_MSTATUS 12'h300
`define WB_CSR_MTVEC 12'h305
`define WB_CSR_MEPC 12'h341
`define WB_CSR_MCAUSE 12'h342
`define WB_CSR_MTVAL 12'h343
// retired-instruction counter, read only
`define WB_CSR_MINSTRET 12'hB02

`endif
